//--- hw/inst_mem_pkg.sv
// ---------------------------------------------------------------------
// Instruction memory package
// Word widths, region map, bank geometry, boot vector and loader image
// ---------------------------------------------------------------------
`default_nettype none

package inst_mem_pkg;

    localparam int ADDR_W = 14;
    localparam int DATA_W = 16;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;

    // Region map, RAM below the bootloader
    localparam int RAM_WORDS  = 16000;
    localparam int BOOT_START = 16000;
    localparam int BOOT_WORDS = 384;
    localparam int ROM_ADDR_W = 9;

    localparam int BANK_COUNT  = 4;
    localparam int BANK_WORDS  = 4000;
    localparam int BANK_ADDR_W = 12;
    localparam int BANK_SEL_W  = 2;

    typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

    // Word 0 holds the bootloader byte address, words 1 to 3 load it and jump
    localparam int INIT_LEN = 8;
    localparam word_t BOOT_VECTOR [INIT_LEN] = '{
        16'h7D00, 16'h0000, 16'hD020, 16'h001E,
        16'h0000, 16'h0000, 16'h0000, 16'h0000
    };

    // Loader program, rest of the ROM reads as zero
    localparam int BOOT_IMAGE_LEN = 16;
    localparam word_t BOOT_IMAGE [BOOT_IMAGE_LEN] = '{
        16'h1000, 16'h2100, 16'hD000, 16'h4012,
        16'h3110, 16'h8021, 16'hD010, 16'h5001,
        16'h6120, 16'h9002, 16'h003A, 16'h1200,
        16'hA031, 16'h7102, 16'hD020, 16'h001E
    };

    typedef enum logic [2:0] {
        REGION_BANK0,
        REGION_BANK1,
        REGION_BANK2,
        REGION_BANK3,
        REGION_ROM,
        REGION_NONE
    } region_t;

endpackage

`default_nettype wire

//--- hw/boot_vector_init.sv
// ---------------------------------------------------------------------
// Boot vector initializer
// Writes the boot vector into the first RAM words after reset,
// then hands the memory over to the processor bus
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module boot_vector_init
    import inst_mem_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output logic  init_active,
    output addr_t init_addr,
    output word_t init_data,
    output logic  inst_ready
);

    logic [2:0] count;

    // Steps through the vector, holds on the last word
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            count      <= '0;
            inst_ready <= 1'b0;
        end
        else if (count == 3'(INIT_LEN - 1))
        begin
            inst_ready <= 1'b1;
        end
        else
        begin
            count <= count + 3'd1;
        end
    end

    assign init_active = ~inst_ready;
    assign init_addr   = addr_t'(count);
    assign init_data   = BOOT_VECTOR[count];

endmodule

`default_nettype wire

//--- hw/bank_router.sv
// ---------------------------------------------------------------------
// Request router
// Picks the initializer or the bus and steers the access to one RAM
// bank or to the ROM, with the region tag of any read
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module bank_router
    import inst_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  init_active,
    input  addr_t                 init_addr,
    input  word_t                 init_data,
    input  logic                  enable,
    input  logic                  write_en,
    input  addr_t                 addr,
    input  word_t                 data_in,
    output logic [BANK_COUNT-1:0] bank_en,
    output logic                  bank_we,
    output bank_addr_t            bank_addr,
    output word_t                 bank_data,
    output logic                  rom_en,
    output logic [ROM_ADDR_W-1:0] rom_addr,
    output region_t               rd_region
);

    logic                  bus_open;
    logic                  req_valid;
    logic                  req_we;
    addr_t                 req_addr;
    word_t                 req_data;
    logic                  in_rom;
    logic [BANK_SEL_W-1:0] bank_sel;
    addr_t                 bank_base;

    // Bus opens together with the last boot vector write
    always_ff @(posedge clk)
    begin
        if (!reset)
            bus_open <= 1'b0;
        else if (init_active && init_addr == addr_t'(INIT_LEN - 1))
            bus_open <= 1'b1;
    end

    always_comb
    begin
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_addr  = '0;
        req_data  = '0;
        if (init_active)
        begin
            req_valid = 1'b1;
            req_we    = 1'b1;
            req_addr  = init_addr;
            req_data  = init_data;
        end
        else if (bus_open && enable)
        begin
            req_valid = 1'b1;
            req_we    = write_en;
            req_addr  = addr;
            req_data  = data_in;
        end
    end

    // Highest bank whose base is not above the address
    always_comb
    begin
        bank_sel  = '0;
        bank_base = '0;
        for (int i = 0; i < BANK_COUNT; i++)
        begin
            if (req_addr >= addr_t'(i * BANK_WORDS))
            begin
                bank_sel  = BANK_SEL_W'(i);
                bank_base = addr_t'(i * BANK_WORDS);
            end
        end
    end

    assign in_rom = (req_addr >= addr_t'(BOOT_START));

    always_comb
    begin
        bank_en = '0;
        if (req_valid && !in_rom)
            bank_en[bank_sel] = 1'b1;
    end

    assign bank_we   = req_we;
    assign bank_addr = bank_addr_t'(req_addr - bank_base);
    assign bank_data = req_data;

    // ROM writes fall through here with no enable
    assign rom_en   = req_valid && in_rom && !req_we;
    assign rom_addr = ROM_ADDR_W'(req_addr - addr_t'(BOOT_START));

    always_comb
    begin
        if (!req_valid || req_we)
            rd_region = REGION_NONE;
        else if (in_rom)
            rd_region = REGION_ROM;
        else
            rd_region = region_t'(3'(bank_sel));
    end

endmodule

`default_nettype wire

//--- hw/ram_bank.sv
// ---------------------------------------------------------------------
// RAM bank
// Single-port synchronous RAM, registered read word that is zero
// on every cycle without a read
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ram_bank
    import inst_mem_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       en,
    input  logic       we,
    input  bank_addr_t addr,
    input  word_t      wdata,
    output word_t      rdata
);

    word_t mem [BANK_WORDS];

    always_ff @(posedge clk)
    begin
        if (en && we)
            mem[addr] <= wdata;
    end

    // Output register, cleared unless this bank is read
    always_ff @(posedge clk)
    begin
        if (!reset)
            rdata <= '0;
        else if (en && !we)
            rdata <= mem[addr];
        else
            rdata <= '0;
    end

endmodule

`default_nettype wire

//--- hw/boot_rom.sv
// ---------------------------------------------------------------------
// Bootloader ROM
// Fixed loader image with a registered read word, zero when idle
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module boot_rom
    import inst_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  en,
    input  logic [ROM_ADDR_W-1:0] addr,
    output word_t                 rdata
);

    word_t image_word;

    // Offsets past the image read as zero
    always_comb
    begin
        image_word = '0;
        for (int i = 0; i < BOOT_IMAGE_LEN; i++)
        begin
            if (addr == ROM_ADDR_W'(i))
                image_word = BOOT_IMAGE[i];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
            rdata <= '0;
        else if (en)
            rdata <= image_word;
        else
            rdata <= '0;
    end

endmodule

`default_nettype wire

//--- hw/read_merge.sv
// ---------------------------------------------------------------------
// Read merge
// Remembers which region the last read went to and returns
// only that region's word
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module read_merge
    import inst_mem_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  region_t rd_region,
    input  word_t   bank_rdata [BANK_COUNT],
    input  word_t   rom_rdata,
    output word_t   data_out
);

    region_t last_region;

    // Aligned with the registered outputs of the storage blocks
    always_ff @(posedge clk)
    begin
        if (!reset)
            last_region <= REGION_NONE;
        else
            last_region <= rd_region;
    end

    // Other blocks are ignored, even if their word is not zero
    always_comb
    begin
        data_out = '0;
        if (last_region == REGION_ROM)
        begin
            data_out = rom_rdata;
        end
        else
        begin
            for (int i = 0; i < BANK_COUNT; i++)
            begin
                if (last_region == region_t'(3'(i)))
                    data_out = bank_rdata[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/inst_mem.sv
// ---------------------------------------------------------------------
// Instruction memory top level
// Banked RAM with a boot vector written after reset, plus the
// bootloader ROM, behind a one-cycle processor bus
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module inst_mem
    import inst_mem_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  enable,
    input  logic  write_en,
    input  addr_t addr,
    input  word_t data_in,
    output word_t data_out,
    output logic  inst_ready
);

    logic                  init_active;
    addr_t                 init_addr;
    word_t                 init_data;
    logic [BANK_COUNT-1:0] bank_en;
    logic                  bank_we;
    bank_addr_t            bank_addr;
    word_t                 bank_data;
    word_t                 bank_rdata [BANK_COUNT];
    logic                  rom_en;
    logic [ROM_ADDR_W-1:0] rom_addr;
    word_t                 rom_rdata;
    region_t               rd_region;

    boot_vector_init u_init (
        .clk         (clk),
        .reset       (reset),
        .init_active (init_active),
        .init_addr   (init_addr),
        .init_data   (init_data),
        .inst_ready  (inst_ready)
    );

    bank_router u_router (
        .clk         (clk),
        .reset       (reset),
        .init_active (init_active),
        .init_addr   (init_addr),
        .init_data   (init_data),
        .enable      (enable),
        .write_en    (write_en),
        .addr        (addr),
        .data_in     (data_in),
        .bank_en     (bank_en),
        .bank_we     (bank_we),
        .bank_addr   (bank_addr),
        .bank_data   (bank_data),
        .rom_en      (rom_en),
        .rom_addr    (rom_addr),
        .rd_region   (rd_region)
    );

    // Banks share address and data, only the enable differs
    for (genvar i = 0; i < BANK_COUNT; i++)
    begin : g_bank
        ram_bank u_bank (
            .clk   (clk),
            .reset (reset),
            .en    (bank_en[i]),
            .we    (bank_we),
            .addr  (bank_addr),
            .wdata (bank_data),
            .rdata (bank_rdata[i])
        );
    end

    boot_rom u_rom (
        .clk   (clk),
        .reset (reset),
        .en    (rom_en),
        .addr  (rom_addr),
        .rdata (rom_rdata)
    );

    read_merge u_merge (
        .clk        (clk),
        .reset      (reset),
        .rd_region  (rd_region),
        .bank_rdata (bank_rdata),
        .rom_rdata  (rom_rdata),
        .data_out   (data_out)
    );

endmodule

`default_nettype wire

//--- verif/inst_mem_tb.sv
// ---------------------------------------------------------------------
// Instruction memory testbench
// Directed tests of boot vector init, RAM banks, ROM and idle cycles
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module inst_mem_tb
    import inst_mem_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;

    logic  clk;
    logic  reset;
    logic  enable;
    logic  write_en;
    addr_t addr;
    word_t data_in;
    word_t data_out;
    logic  inst_ready;

    int          word_errors = 0;
    int          ready_errors = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state = 32'h129ac644;

    // Expected data_out, one cycle behind each request
    string exp_name [$];
    word_t exp_word [$];

    inst_mem DUT (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .write_en   (write_en),
        .addr       (addr),
        .data_in    (data_in),
        .data_out   (data_out),
        .inst_ready (inst_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    function automatic word_t rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            word_errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_ready(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            ready_errors++;
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // One bus cycle, then check the result of the previous request
    task automatic bus_cycle(input string name, input logic en, input logic we,
                             input addr_t a, input word_t d, input word_t exp);
        string old_name;
        word_t old_word;
        @(posedge clk);
        enable   <= en;
        write_en <= we;
        addr     <= a;
        data_in  <= d;
        exp_name.push_back(name);
        exp_word.push_back(exp);
        @(negedge clk);
        if (exp_word.size() > 1)
        begin
            old_name = exp_name.pop_front();
            old_word = exp_word.pop_front();
            compare_word(old_name, old_word, data_out);
        end
    endtask

    task automatic write_word(input string name, input addr_t a, input word_t d);
        bus_cycle(name, 1'b1, 1'b1, a, d, '0);
    endtask

    task automatic read_word(input string name, input addr_t a, input word_t exp);
        bus_cycle(name, 1'b1, 1'b0, a, '0, exp);
    endtask

    task automatic idle_cycle(input string name);
        bus_cycle(name, 1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic test_init();
        repeat (3) @(posedge clk);
        @(negedge clk);
        compare_ready("reset ready", 1'b0, inst_ready);
        compare_word("reset data", '0, data_out);
        @(posedge clk);
        reset <= 1'b1;
        // These writes arrive while the boot vector is written
        for (int i = 1; i <= 8; i++)
        begin
            if (i < 8)
                write_word($sformatf("init write %0d", i), addr_t'(i - 1), 16'hBAD0 + i);
            else
                idle_cycle("init idle");
            compare_ready($sformatf("init ready %0d", i), i == 8, inst_ready);
        end
    endtask

    task automatic test_boot_vector();
        for (int i = 0; i < INIT_LEN; i++)
            read_word($sformatf("boot vector %0d", i), addr_t'(i), BOOT_VECTOR[i]);
    endtask

    task automatic test_ram_banks();
        addr_t a [BANK_COUNT*3];
        word_t w [BANK_COUNT*3];
        int    base;
        int    redo [4] = '{0, 2, 3, 11};
        for (int b = 0; b < BANK_COUNT; b++)
        begin
            base       = b * BANK_WORDS;
            a[3*b]     = addr_t'(base);
            a[3*b + 1] = addr_t'(base + 1 + int'(rand_word()) % (BANK_WORDS - 2));
            a[3*b + 2] = addr_t'(base + BANK_WORDS - 1);
        end
        for (int i = 0; i < BANK_COUNT * 3; i++)
        begin
            w[i] = rand_word();
            write_word($sformatf("ram write %0d", a[i]), a[i], w[i]);
        end
        for (int i = 0; i < BANK_COUNT * 3; i++)
            read_word($sformatf("ram read %0d", a[i]), a[i], w[i]);
        // Overwrite word 0, both sides of the bank 0/1 edge and the top word
        foreach (redo[j])
        begin
            w[redo[j]] = rand_word();
            write_word($sformatf("ram rewrite %0d", a[redo[j]]), a[redo[j]], w[redo[j]]);
        end
        for (int i = 0; i < BANK_COUNT * 3; i++)
            read_word($sformatf("ram reread %0d", a[i]), a[i], w[i]);
    endtask

    task automatic test_rom();
        for (int i = 0; i < BOOT_IMAGE_LEN; i++)
            read_word($sformatf("rom %0d", i), addr_t'(BOOT_START + i), BOOT_IMAGE[i]);
        read_word("rom past image", addr_t'(BOOT_START + BOOT_IMAGE_LEN), '0);
        read_word("rom middle", addr_t'(BOOT_START + 200), '0);
        read_word("rom top", addr_t'(BOOT_START + BOOT_WORDS - 1), '0);
        write_word("rom write image", addr_t'(BOOT_START + 5), 16'hFFFF);
        read_word("rom read image", addr_t'(BOOT_START + 5), BOOT_IMAGE[5]);
        write_word("rom write blank", addr_t'(BOOT_START + 300), 16'h1234);
        read_word("rom read blank", addr_t'(BOOT_START + 300), '0);
    endtask

    task automatic test_idle();
        word_t w1;
        word_t w2;
        w1 = rand_word();
        w2 = rand_word();
        write_word("idle setup", addr_t'(100), w1);
        idle_cycle("idle after write");
        read_word("read after idle", addr_t'(100), w1);
        idle_cycle("idle after read");
        bus_cycle("disabled write", 1'b0, 1'b1, addr_t'(100), ~w1, '0);
        bus_cycle("disabled read", 1'b0, 1'b0, addr_t'(100), '0, '0);
        read_word("read after disabled write", addr_t'(100), w1);
        // Read right behind the write sees the new word
        write_word("write then read", addr_t'(200), w2);
        read_word("read behind write", addr_t'(200), w2);
    endtask

    initial
    begin
        reset    = 1'b0;
        enable   = 1'b0;
        write_en = 1'b0;
        addr     = '0;
        data_in  = '0;

        test_init();
        test_boot_vector();
        test_ram_banks();
        test_rom();
        test_idle();
        idle_cycle("drain 1");
        idle_cycle("drain 2");
        compare_ready("ready held", 1'b1, inst_ready);

        $display("Errors: word %0d, ready %0d", word_errors, ready_errors);
        if (word_errors + ready_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- inst_mem.f
hw/inst_mem_pkg.sv
hw/boot_vector_init.sv
hw/bank_router.sv
hw/ram_bank.sv
hw/boot_rom.sv
hw/read_merge.sv
hw/inst_mem.sv
verif/inst_mem_tb.sv
